//--- all.f
common/lc3b_isa_pkg.sv
common/commit_pkg.sv
commit/commit_control.sv
commit/branch_resolve.sv
commit/branch_stats.sv
design/commit_stage.sv
verification/commit_asserts.sv
verification/commit_checker.sv
verification/tb_commit_stage.sv

//--- commit/branch_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolve
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire logic              ld_cc,
	input  lc3b_isa_pkg::lc3b_word wb_value,
	input  commit_pkg::rob_head_t  head,
	output logic                   taken,
	output logic                   mispredict,
	output lc3b_isa_pkg::lc3b_word next_pc
);

	lc3b_isa_pkg::lc3b_nzp gen_cc;
	lc3b_isa_pkg::lc3b_nzp cc;
	lc3b_isa_pkg::lc3b_nzp br_mask;
	lc3b_isa_pkg::lc3b_word fall_through;

	// nzp of the committed result
	always_comb
	begin
		if (wb_value[lc3b_isa_pkg::word_width-1])
			gen_cc = 3'b100;
		else if (wb_value == '0)
			gen_cc = 3'b010;
		else
			gen_cc = 3'b001;
	end

	// Architectural condition codes, updated only at commit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cc <= 3'b010;
		else if (ld_cc)
			cc <= gen_cc;
	end

	// A branch carries its nzp mask in the dest field
	assign br_mask = head.dest;
	assign taken = |(cc & br_mask);
	assign mispredict = (taken != head.predict);

	assign fall_through = head.pc + lc3b_isa_pkg::pc_increment;
	assign next_pc = taken ? (fall_through + head.value) : fall_through;

endmodule : branch_resolve

`default_nettype wire

//--- commit/branch_stats.sv
`timescale 1ns/1ns
`default_nettype none

module branch_stats
(
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire logic                valid,
	input  lc3b_isa_pkg::lc3b_opcode opcode,
	input  wire logic                mispredict,
	output logic [31:0]              branch_count,
	output logic [31:0]              mispredict_count
);

	logic is_branch;

	assign is_branch = valid && (opcode == lc3b_isa_pkg::op_br);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			branch_count <= '0;
			mispredict_count <= '0;
		end
		else if (is_branch)
		begin
			branch_count <= branch_count + 32'd1;
			if (mispredict)
				mispredict_count <= mispredict_count + 32'd1;
		end
	end

endmodule : branch_stats

`default_nettype wire

//--- commit/commit_control.sv
`timescale 1ns/1ns
`default_nettype none

module commit_control
(
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire logic                  valid,
	input  commit_pkg::rob_head_t      head,
	input  lc3b_isa_pkg::lc3b_rob_addr rob_addr,
	input  lc3b_isa_pkg::lc3b_rob_addr busy_tag,
	input  wire logic                  dmem_resp,
	input  wire logic                  taken,
	input  wire logic                  mispredict,
	input  lc3b_isa_pkg::lc3b_word     next_pc,
	output logic                       ld_cc,
	output commit_pkg::regfile_wr_t    regfile,
	output logic                       retire,
	output commit_pkg::redirect_t      redirect,
	output logic                       dmem_write,
	output logic                       ldst_retire,
	output commit_pkg::btb_wr_t        btb,
	output commit_pkg::pred_upd_t      pred
);

	// LDI occupies two ROB entries, retired in order
	typedef enum logic {
		ldi_first,
		ldi_second
	} ldi_phase_t;

	ldi_phase_t ldi_phase;
	logic busy_match;

	// Only clear busy if no younger writer has claimed the register
	assign busy_match = (busy_tag == rob_addr);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ldi_phase <= ldi_first;
		else if (valid && head.opcode == lc3b_isa_pkg::op_ldi)
			ldi_phase <= (ldi_phase == ldi_first) ? ldi_second : ldi_first;
	end

	always_comb
	begin
		regfile.dest = head.dest;
		regfile.value = (head.opcode == lc3b_isa_pkg::op_trap) ? head.trap_reg : head.value;
		regfile.ld_value = 1'b0;
		regfile.ld_busy = 1'b0;
		ld_cc = 1'b0;
		retire = 1'b0;
		redirect = '0;
		dmem_write = 1'b0;
		ldst_retire = 1'b0;
		btb = '0;
		pred.ld = 1'b0;
		pred.taken = taken;
		pred.bht = head.bht;
		pred.pc = head.pc;

		if (valid)
		begin
			case (head.opcode)
				lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not,
				lc3b_isa_pkg::op_shf, lc3b_isa_pkg::op_lea, lc3b_isa_pkg::op_ldr,
				lc3b_isa_pkg::op_ldb:
				begin
					regfile.ld_value = 1'b1;
					regfile.ld_busy = busy_match;
					ld_cc = 1'b1;
					retire = 1'b1;
				end
				lc3b_isa_pkg::op_jsr:
				begin
					// Link register write leaves the condition codes alone
					regfile.ld_value = 1'b1;
					regfile.ld_busy = busy_match;
					retire = 1'b1;
				end
				lc3b_isa_pkg::op_ldi:
				begin
					retire = 1'b1;
					if (ldi_phase == ldi_second)
					begin
						regfile.ld_value = 1'b1;
						regfile.ld_busy = busy_match;
						ld_cc = 1'b1;
					end
				end
				lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_sti:
				begin
					// Hold the write until memory acknowledges it
					dmem_write = 1'b1;
					retire = dmem_resp;
					ldst_retire = dmem_resp;
				end
				lc3b_isa_pkg::op_br:
				begin
					retire = 1'b1;
					pred.ld = 1'b1;
					redirect.new_pc = next_pc;
					redirect.sel = mispredict;
					redirect.flush = mispredict;
					btb.we = 1'b1;
					btb.index = head.pc[commit_pkg::btb_index_lsb +: commit_pkg::btb_index_width];
					btb.tag = head.pc[commit_pkg::btb_tag_lsb +: commit_pkg::btb_tag_width];
					btb.target = next_pc;
					btb.valid = 1'b1;
					btb.predict = taken;
				end
				lc3b_isa_pkg::op_trap:
				begin
					redirect.sel = 1'b1;
					redirect.new_pc = head.value;
					redirect.flush = 1'b1;
					regfile.ld_value = 1'b1;
					regfile.ld_busy = busy_match;
					retire = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule : commit_control

`default_nettype wire

//--- common/commit_pkg.sv
`default_nettype none

package commit_pkg;

	// BTB is direct mapped on the halfword-aligned PC
	localparam int btb_index_width = 6;
	localparam int btb_index_lsb = 1;
	localparam int btb_tag_width = 9;
	localparam int btb_tag_lsb = 7;

	typedef logic [btb_index_width-1:0] btb_index;
	typedef logic [btb_tag_width-1:0] btb_tag;

	// Entry at the head of the reorder buffer
	typedef struct packed {
		lc3b_isa_pkg::lc3b_opcode opcode;
		// Destination register, or the nzp mask of a branch
		lc3b_isa_pkg::lc3b_reg dest;
		// Result, branch offset or trap vector
		lc3b_isa_pkg::lc3b_word value;
		logic predict;
		lc3b_isa_pkg::lc3b_word pc;
		lc3b_isa_pkg::lc3b_bht_out bht;
		// Return address written by TRAP
		lc3b_isa_pkg::lc3b_word trap_reg;
	} rob_head_t;

	typedef struct packed {
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_word value;
		logic ld_value;
		logic ld_busy;
	} regfile_wr_t;

	typedef struct packed {
		logic sel;
		lc3b_isa_pkg::lc3b_word new_pc;
		logic flush;
	} redirect_t;

	typedef struct packed {
		logic we;
		btb_index index;
		btb_tag tag;
		lc3b_isa_pkg::lc3b_word target;
		logic valid;
		logic predict;
	} btb_wr_t;

	typedef struct packed {
		logic ld;
		logic taken;
		lc3b_isa_pkg::lc3b_bht_out bht;
		lc3b_isa_pkg::lc3b_word pc;
	} pred_upd_t;

endpackage : commit_pkg

`default_nettype wire

//--- common/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	localparam int word_width = 16;
	localparam int reg_width = 3;
	localparam int nzp_width = 3;
	localparam int rob_addr_width = 3;
	localparam int bht_width = 2;

	// Sequential fetch advances by one 16-bit instruction
	localparam logic [word_width-1:0] pc_increment = 16'd2;

	typedef logic [word_width-1:0] lc3b_word;
	typedef logic [reg_width-1:0] lc3b_reg;
	typedef logic [nzp_width-1:0] lc3b_nzp;
	typedef logic [rob_addr_width-1:0] lc3b_rob_addr;

	// Two-bit saturating counter state carried by a branch
	typedef logic [bht_width-1:0] lc3b_bht_out;

	// Encodings follow the LC-3b instruction word bits 15:12
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

`default_nettype wire

//--- design/commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

module commit_stage
(
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire logic                  valid,
	input  commit_pkg::rob_head_t      head,
	input  wire logic                  rob_empty,
	input  lc3b_isa_pkg::lc3b_rob_addr rob_addr,
	input  lc3b_isa_pkg::lc3b_rob_addr busy_tag,
	input  wire logic                  dmem_resp,
	output commit_pkg::regfile_wr_t    regfile,
	output logic                       retire,
	output commit_pkg::redirect_t      redirect,
	output logic                       dmem_write,
	output logic                       ldst_retire,
	output commit_pkg::btb_wr_t        btb,
	output commit_pkg::pred_upd_t      pred,
	output logic [31:0]                branch_count,
	output logic [31:0]                mispredict_count
);

	logic head_valid;
	logic ld_cc;
	logic taken;
	logic mispredict;
	lc3b_isa_pkg::lc3b_word next_pc;

	// An empty ROB never presents a committable head
	assign head_valid = valid && !rob_empty;

	commit_control i_commit_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid       (head_valid),
		.head        (head),
		.rob_addr    (rob_addr),
		.busy_tag    (busy_tag),
		.dmem_resp   (dmem_resp),
		.taken       (taken),
		.mispredict  (mispredict),
		.next_pc     (next_pc),
		.ld_cc       (ld_cc),
		.regfile     (regfile),
		.retire      (retire),
		.redirect    (redirect),
		.dmem_write  (dmem_write),
		.ldst_retire (ldst_retire),
		.btb         (btb),
		.pred        (pred)
	);

	branch_resolve i_branch_resolve (
		.clk        (clk),
		.rst_n      (rst_n),
		.ld_cc      (ld_cc),
		.wb_value   (regfile.value),
		.head       (head),
		.taken      (taken),
		.mispredict (mispredict),
		.next_pc    (next_pc)
	);

	branch_stats i_branch_stats (
		.clk              (clk),
		.rst_n            (rst_n),
		.valid            (head_valid),
		.opcode           (head.opcode),
		.mispredict       (mispredict),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

endmodule : commit_stage

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_commit_stage
sim_output=$(./obj_dir/Vtb_commit_stage +verilator+error+limit+1000) || true
echo "$sim_output"
if echo "$sim_output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

//--- verification/commit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module commit_asserts
(
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire logic             valid,
	input  wire logic             retire,
	input  commit_pkg::redirect_t redirect,
	input  wire logic             dmem_write,
	input  wire logic             dmem_resp,
	input  wire logic             ldst_retire
);

	// Running count of failed assertions
	int failures = 0;

	retire_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!valid |-> !retire)
	else
	begin
		failures++;
		$error("retire raised while valid is low");
	end

	flush_needs_sel: assert property (@(posedge clk) disable iff (!rst_n)
		redirect.flush |-> redirect.sel)
	else
	begin
		failures++;
		$error("flush raised without a redirect");
	end

	// A store pops the load/store buffer exactly on the memory response
	store_pop_on_resp: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_write |-> (ldst_retire == dmem_resp))
	else
	begin
		failures++;
		$error("ldst_retire does not follow dmem_resp during a store");
	end

endmodule : commit_asserts

`default_nettype wire

//--- verification/commit_checker.sv
`timescale 1ns/1ns
`default_nettype none

module commit_checker
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  commit_pkg::regfile_wr_t regfile,
	input  wire logic               retire,
	input  commit_pkg::redirect_t   redirect,
	input  wire logic               dmem_write,
	input  wire logic               ldst_retire,
	input  commit_pkg::btb_wr_t     btb,
	input  commit_pkg::pred_upd_t   pred,
	input  wire logic [31:0]        branch_count,
	input  wire logic [31:0]        mispredict_count,
	input  commit_pkg::regfile_wr_t exp_regfile,
	input  wire logic               exp_retire,
	input  commit_pkg::redirect_t   exp_redirect,
	input  wire logic               exp_dmem_write,
	input  wire logic               exp_ldst_retire,
	input  commit_pkg::btb_wr_t     exp_btb,
	input  commit_pkg::pred_upd_t   exp_pred,
	input  wire logic [31:0]        exp_branch_count,
	input  wire logic [31:0]        exp_mispredict_count,
	output int                      error_count,
	output int                      check_count
);

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// Outputs settle a half cycle after the inputs change
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			compare("retire", 64'(exp_retire), 64'(retire));
			compare("dmem_write", 64'(exp_dmem_write), 64'(dmem_write));
			compare("ldst_retire", 64'(exp_ldst_retire), 64'(ldst_retire));
			compare("regfile.ld_value", 64'(exp_regfile.ld_value), 64'(regfile.ld_value));
			compare("regfile.ld_busy", 64'(exp_regfile.ld_busy), 64'(regfile.ld_busy));
			// Data fields only matter when their strobe is set
			if (exp_regfile.ld_value)
			begin
				compare("regfile.dest", 64'(exp_regfile.dest), 64'(regfile.dest));
				compare("regfile.value", 64'(exp_regfile.value), 64'(regfile.value));
			end
			compare("redirect.sel", 64'(exp_redirect.sel), 64'(redirect.sel));
			compare("redirect.flush", 64'(exp_redirect.flush), 64'(redirect.flush));
			if (exp_redirect.sel)
				compare("redirect.new_pc", 64'(exp_redirect.new_pc), 64'(redirect.new_pc));
			compare("btb.we", 64'(exp_btb.we), 64'(btb.we));
			if (exp_btb.we)
			begin
				compare("btb.index", 64'(exp_btb.index), 64'(btb.index));
				compare("btb.tag", 64'(exp_btb.tag), 64'(btb.tag));
				compare("btb.target", 64'(exp_btb.target), 64'(btb.target));
				compare("btb.valid", 64'(exp_btb.valid), 64'(btb.valid));
				compare("btb.predict", 64'(exp_btb.predict), 64'(btb.predict));
			end
			compare("pred.ld", 64'(exp_pred.ld), 64'(pred.ld));
			if (exp_pred.ld)
			begin
				compare("pred.taken", 64'(exp_pred.taken), 64'(pred.taken));
				compare("pred.bht", 64'(exp_pred.bht), 64'(pred.bht));
				compare("pred.pc", 64'(exp_pred.pc), 64'(pred.pc));
			end
			compare("branch_count", 64'(exp_branch_count), 64'(branch_count));
			compare("mispredict_count", 64'(exp_mispredict_count), 64'(mispredict_count));
		end
	end

endmodule : commit_checker

`default_nettype wire

//--- verification/tb_commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_commit_stage;

	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	localparam int num_entries = 400;
	// Covers idle gaps, LDI pairs and the longest store wait
	localparam int cycles_per_entry = 8;
	localparam int timeout_ns = num_entries * cycles_per_entry * clk_period;

	typedef struct packed {
		commit_pkg::regfile_wr_t regfile;
		logic retire;
		commit_pkg::redirect_t redirect;
		logic dmem_write;
		logic ldst_retire;
		commit_pkg::btb_wr_t btb;
		commit_pkg::pred_upd_t pred;
		logic ld_cc;
		logic mispredict;
	} expect_t;

	logic clk;
	logic rst_n;
	logic valid;
	logic rob_empty;
	logic dmem_resp;
	commit_pkg::rob_head_t head;
	lc3b_isa_pkg::lc3b_rob_addr rob_addr;
	lc3b_isa_pkg::lc3b_rob_addr busy_tag;
	commit_pkg::regfile_wr_t regfile;
	logic retire;
	commit_pkg::redirect_t redirect;
	logic dmem_write;
	logic ldst_retire;
	commit_pkg::btb_wr_t btb;
	commit_pkg::pred_upd_t pred;
	logic [31:0] branch_count;
	logic [31:0] mispredict_count;

	expect_t expected;
	lc3b_isa_pkg::lc3b_nzp model_cc;
	logic model_ldi_second;
	logic [31:0] model_branches;
	logic [31:0] model_mispredicts;
	int error_count;
	int check_count;
	int mem_wait;

	lc3b_isa_pkg::lc3b_opcode op_list [14] = '{
		lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not,
		lc3b_isa_pkg::op_shf, lc3b_isa_pkg::op_lea, lc3b_isa_pkg::op_ldr,
		lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_ldi,
		lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_sti,
		lc3b_isa_pkg::op_br, lc3b_isa_pkg::op_trap
	};

	commit_stage i_commit_stage (.*);

	bind commit_control commit_asserts i_commit_asserts (.*);

	commit_checker i_commit_checker (
		.clk                  (clk),
		.rst_n                (rst_n),
		.regfile              (regfile),
		.retire               (retire),
		.redirect             (redirect),
		.dmem_write           (dmem_write),
		.ldst_retire          (ldst_retire),
		.btb                  (btb),
		.pred                 (pred),
		.branch_count         (branch_count),
		.mispredict_count     (mispredict_count),
		.exp_regfile          (expected.regfile),
		.exp_retire           (expected.retire),
		.exp_redirect         (expected.redirect),
		.exp_dmem_write       (expected.dmem_write),
		.exp_ldst_retire      (expected.ldst_retire),
		.exp_btb              (expected.btb),
		.exp_pred             (expected.pred),
		.exp_branch_count     (model_branches),
		.exp_mispredict_count (model_mispredicts),
		.error_count          (error_count),
		.check_count          (check_count)
	);

	function automatic lc3b_isa_pkg::lc3b_nzp nzp_of(input lc3b_isa_pkg::lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic expect_t commit_model(
		input logic live,
		input commit_pkg::rob_head_t h,
		input lc3b_isa_pkg::lc3b_rob_addr addr,
		input lc3b_isa_pkg::lc3b_rob_addr busy,
		input logic resp,
		input lc3b_isa_pkg::lc3b_nzp cc,
		input logic ldi_second
	);
		expect_t e;
		logic taken;
		logic writes;
		lc3b_isa_pkg::lc3b_word target;
		e = '0;
		writes = 1'b0;
		taken = |(cc & h.dest);
		target = h.pc + 16'd2 + (taken ? h.value : 16'd0);
		e.mispredict = (taken != h.predict);
		e.regfile.dest = h.dest;
		e.regfile.value = (h.opcode == lc3b_isa_pkg::op_trap) ? h.trap_reg : h.value;
		if (live)
		begin
			case (h.opcode)
				lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not,
				lc3b_isa_pkg::op_shf, lc3b_isa_pkg::op_lea, lc3b_isa_pkg::op_ldr,
				lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_jsr:
				begin
					writes = 1'b1;
					e.ld_cc = (h.opcode != lc3b_isa_pkg::op_jsr);
					e.retire = 1'b1;
				end
				lc3b_isa_pkg::op_ldi:
				begin
					writes = ldi_second;
					e.ld_cc = ldi_second;
					e.retire = 1'b1;
				end
				lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_sti:
				begin
					e.dmem_write = 1'b1;
					e.retire = resp;
					e.ldst_retire = resp;
				end
				lc3b_isa_pkg::op_br:
				begin
					e.retire = 1'b1;
					e.redirect.sel = e.mispredict;
					e.redirect.flush = e.mispredict;
					e.redirect.new_pc = target;
					e.btb = '{we: 1'b1, index: h.pc[6:1], tag: h.pc[15:7], target: target,
						valid: 1'b1, predict: taken};
					e.pred = '{ld: 1'b1, taken: taken, bht: h.bht, pc: h.pc};
				end
				lc3b_isa_pkg::op_trap:
				begin
					writes = 1'b1;
					e.retire = 1'b1;
					e.redirect = '{sel: 1'b1, new_pc: h.value, flush: 1'b1};
				end
				default: ;
			endcase
		end
		e.regfile.ld_value = writes;
		e.regfile.ld_busy = writes && (busy == addr);
		return e;
	endfunction

	always_comb
		expected = commit_model(valid && !rob_empty, head, rob_addr, busy_tag, dmem_resp,
			model_cc, model_ldi_second);

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			model_cc <= 3'b010;
			model_ldi_second <= 1'b0;
			model_branches <= '0;
			model_mispredicts <= '0;
		end
		else
		begin
			if (expected.ld_cc)
				model_cc <= nzp_of(head.value);
			if (valid && !rob_empty && head.opcode == lc3b_isa_pkg::op_ldi)
				model_ldi_second <= !model_ldi_second;
			if (valid && !rob_empty && head.opcode == lc3b_isa_pkg::op_br)
			begin
				model_branches <= model_branches + 32'd1;
				if (expected.mispredict)
					model_mispredicts <= model_mispredicts + 32'd1;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic commit_pkg::rob_head_t random_head();
		commit_pkg::rob_head_t h;
		logic [31:0] r1;
		logic [31:0] r2;
		int idx;
		r1 = $urandom;
		r2 = $urandom;
		idx = $urandom_range(13, 0);
		h.opcode = op_list[idx];
		h.dest = r1[2:0];
		h.predict = r1[3];
		h.bht = r1[5:4];
		// Zero results now and then so the z code gets exercised
		h.value = (r1[7:6] == 2'b00) ? 16'h0000 : r1[31:16];
		h.pc = {r2[15:1], 1'b0};
		h.trap_reg = r2[31:16];
		return h;
	endfunction

	task automatic idle_cycles(input int n);
		logic [31:0] r;
		repeat (n)
		begin
			r = $urandom;
			// Either valid is low or the ROB reports empty
			valid = r[0];
			rob_empty = r[0] | r[1];
			head = random_head();
			@(posedge clk);
			#1;
		end
	endtask

	// Hold the entry at the head until the DUT retires it
	task automatic present_entry(input commit_pkg::rob_head_t h);
		logic [31:0] r;
		logic done;
		r = $urandom;
		valid = 1'b1;
		rob_empty = 1'b0;
		head = h;
		rob_addr = r[2:0];
		busy_tag = r[3] ? r[2:0] : r[6:4];
		do
		begin
			@(negedge clk);
			done = retire;
			@(posedge clk);
			#1;
		end
		while (!done);
	endtask

	// Memory acknowledges a held store after a random wait
	initial
	begin
		dmem_resp = 1'b0;
		mem_wait = -1;
		forever
		begin
			@(posedge clk);
			if (dmem_resp)
			begin
				#1;
				dmem_resp = 1'b0;
			end
			else if (dmem_write)
			begin
				if (mem_wait < 0)
					mem_wait = $urandom_range(3, 0);
				if (mem_wait == 0)
				begin
					#1;
					dmem_resp = 1'b1;
					mem_wait = -1;
				end
				else
					mem_wait = mem_wait - 1;
			end
		end
	end

	initial
	begin
		commit_pkg::rob_head_t entry;
		int assert_failures;
		void'($urandom(32'hf963));
		rst_n = 1'b0;
		valid = 1'b0;
		rob_empty = 1'b1;
		head = '0;
		rob_addr = '0;
		busy_tag = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < num_entries; i++)
		begin
			idle_cycles($urandom_range(2, 0));
			entry = random_head();
			present_entry(entry);
			// The second half of an LDI follows right behind the first
			if (entry.opcode == lc3b_isa_pkg::op_ldi)
			begin
				entry = random_head();
				entry.opcode = lc3b_isa_pkg::op_ldi;
				present_entry(entry);
			end
		end
		idle_cycles(2);
		assert_failures = i_commit_stage.i_commit_control.i_commit_asserts.failures;
		$display("Checks: %0d, value errors: %0d, assertion failures: %0d",
			check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(timeout_ns);
		$display("Timeout: the commit stage stopped retiring entries before the run ended");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule : tb_commit_stage

`default_nettype wire
